/* rtl/rename_pkg.sv */
package rename_pkg;

    localparam int pc_width = 32;

    localparam logic [3:0] rob_op_syscall = 4'd1;
    localparam logic [3:0] rob_op_break   = 4'd2;

    // decoded micro-op, latched as one group
    typedef struct packed {
        logic [3:0]  iq_choose;
        logic [4:0]  alu0_op;
        logic [2:0]  alu1_op;
        logic [3:0]  agu_op;
        logic [3:0]  bru_op;
        logic [3:0]  rob_op;
        logic [19:0] alu0_imm;
        logic [16:0] agu_imm;
        logic [25:0] bru_imm;
    } uop_t;

    // one slot at the stage-3 / stage-4 boundary
    typedef struct packed {
        logic                vld;
        logic [pc_width-1:0] pc;
        logic [pc_width-1:0] pc_target;
        logic [2:0]          except;        // fetch/decode exception flags
        logic [14:0]         except_code;
        uop_t                uop;
    } decode_slot_t;

    typedef struct packed {
        logic flush;
        logic hold;
        logic pause;
    } stage_ctrl_t;

    // valid syscall or break recorded in the ROB op
    function automatic logic is_sys_brk(input decode_slot_t slot);
        logic sys_op;
        sys_op = (slot.uop.rob_op == rob_op_syscall) ||
                 (slot.uop.rob_op == rob_op_break);
        return slot.vld && sys_op;
    endfunction

endpackage

/* rtl/trap_scan.sv */
module trap_scan
    import rename_pkg::*;
#(
    parameter int num_slots = 4
) (
    input  decode_slot_t [num_slots-1:0] dec_group,
    output logic         [num_slots-1:0] kill
);

    // the youngest slot's own trap kills nothing, so no flag for it
    logic [num_slots-2:0] trap;

    genvar i;

    generate
        for (i = 0; i < num_slots - 1; i++) begin : g_trap
            logic fetch_exc;
            logic sys_exc;

            assign fetch_exc = |dec_group[i].except;      // any decode-side exception
            assign sys_exc   = is_sys_brk(dec_group[i]);
            assign trap[i]   = fetch_exc || sys_exc;
        end
    endgenerate

    assign kill[0] = 1'b0;                                // oldest slot always survives

    generate
        for (i = 1; i < num_slots; i++) begin : g_kill
            // prefix or over all older slots
            assign kill[i] = kill[i-1] | trap[i-1];
        end
    endgenerate

endmodule

/* rtl/group_stage_reg.sv */
module group_stage_reg
    import rename_pkg::*;
#(
    parameter int num_slots = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  stage_ctrl_t                  ctrl,
    input  decode_slot_t [num_slots-1:0] dec_group,
    input  logic         [num_slots-1:0] kill,
    output decode_slot_t [num_slots-1:0] stage_group
);

    logic advance;                                        // stage free to take new data

    assign advance = !ctrl.flush && !ctrl.hold && !ctrl.pause;

    genvar i;

    generate
        for (i = 0; i < num_slots; i++) begin : g_slot
            decode_slot_t        in_slot;
            logic                sys_brk;
            logic                pc_load;

            logic                vld_q;
            logic [2:0]          except_q;
            logic [pc_width-1:0] pc_q;
            logic [pc_width-1:0] target_q;
            logic [14:0]         code_q;
            uop_t                uop_q;

            assign in_slot = dec_group[i];
            assign sys_brk = is_sys_brk(in_slot);

            // pc only follows live or excepting slots that survive the squash
            assign pc_load = advance && !kill[i] && (in_slot.vld || (|in_slot.except));

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    vld_q    <= 1'b0;
                    except_q <= 3'd0;
                end else if (ctrl.flush) begin
                    vld_q    <= 1'b0;
                    except_q <= 3'd0;
                end else if (ctrl.hold) begin
                    vld_q    <= vld_q;
                    except_q <= except_q;
                end else if (ctrl.pause || kill[i]) begin   // bubble or squashed
                    vld_q    <= 1'b0;
                    except_q <= 3'd0;
                end else begin
                    vld_q    <= in_slot.vld;
                    except_q <= in_slot.except;
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    pc_q     <= '0;
                    target_q <= '0;
                end else if (pc_load) begin
                    pc_q     <= in_slot.pc;
                    target_q <= in_slot.pc_target;
                end
            end

            // captured even while paused or killed
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    code_q <= 15'd0;
                end else if (ctrl.flush) begin
                    code_q <= 15'd0;
                end else if (ctrl.hold) begin
                    code_q <= code_q;
                end else if (sys_brk) begin
                    code_q <= in_slot.except_code;
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    uop_q <= '0;
                end else if (advance) begin                 // kill does not stop the uop
                    uop_q <= in_slot.uop;
                end
            end

            assign stage_group[i] = '{
                vld:         vld_q,
                pc:          pc_q,
                pc_target:   target_q,
                except:      except_q,
                except_code: code_q,
                uop:         uop_q
            };
        end
    endgenerate

endmodule

/* rtl/rename_stage4.sv */
module rename_stage4
    import rename_pkg::*;
#(
    parameter int num_slots = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  stage_ctrl_t                  ctrl,
    input  decode_slot_t [num_slots-1:0] dec_group,
    output decode_slot_t [num_slots-1:0] stage_group
);

    logic [num_slots-1:0] kill;                           // younger-slot squash mask

    trap_scan #(
        .num_slots (num_slots)
    ) u_trap_scan (
        .dec_group (dec_group),
        .kill      (kill)
    );

    group_stage_reg #(
        .num_slots (num_slots)
    ) u_group_stage_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .dec_group   (dec_group),
        .kill        (kill),
        .stage_group (stage_group)
    );

endmodule

/* bench/rename_checks.sv */
module rename_checks
    import rename_pkg::*;
#(
    parameter int num_slots = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  stage_ctrl_t                  ctrl,
    input  decode_slot_t [num_slots-1:0] dec_group,
    input  decode_slot_t [num_slots-1:0] stage_group,
    output int                           checks,
    output int                           errors
);

    timeunit 1ns;
    timeprecision 100ps;

    int n_checks = 0;
    int n_errors = 0;

    logic                         edge_rst = 1'b0;        // rst_n as seen by the last edge
    stage_ctrl_t                  prev_ctrl;
    decode_slot_t [num_slots-1:0] prev_in;
    decode_slot_t [num_slots-1:0] prev_out;

    assign checks = n_checks;
    assign errors = n_errors;

    function automatic logic sys_or_brk(input decode_slot_t s);
        logic sys_op;
        sys_op = (s.uop.rob_op == rob_op_syscall) || (s.uop.rob_op == rob_op_break);
        return s.vld && sys_op;
    endfunction

    function automatic logic slot_traps(input decode_slot_t s);
        return (|s.except) || sys_or_brk(s);
    endfunction

    task automatic compare_field(input string name, input int slot,
                                 input logic [$bits(decode_slot_t)-1:0] got,
                                 input logic [$bits(decode_slot_t)-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("mismatch %s[%0d]: got %h expected %h at %0t ns",
                     name, slot, got, exp, $time);
        end
    endtask

    // outputs must sit at zero until the first clocked edge after release
    task automatic check_reset_state();
        for (int i = 0; i < num_slots; i++) begin
            compare_field("vld", i, stage_group[i].vld, 1'b0);
            compare_field("except", i, stage_group[i].except, 3'd0);
            compare_field("except_code", i, stage_group[i].except_code, 15'd0);
            compare_field("slot", i, stage_group[i], '0);
        end
    endtask

    task automatic check_slots();
        decode_slot_t in_s;
        decode_slot_t exp;
        logic         k;
        logic         advance;
        k       = 1'b0;
        advance = !prev_ctrl.flush && !prev_ctrl.hold && !prev_ctrl.pause;
        for (int i = 0; i < num_slots; i++) begin
            in_s = prev_in[i];
            exp  = prev_out[i];
            if (prev_ctrl.flush) begin
                exp.vld    = 1'b0;
                exp.except = 3'd0;
            end else if (!prev_ctrl.hold && (prev_ctrl.pause || k)) begin
                exp.vld    = 1'b0;
                exp.except = 3'd0;
            end else if (!prev_ctrl.hold) begin
                exp.vld    = in_s.vld;
                exp.except = in_s.except;
            end
            if (advance && !k && (in_s.vld || (|in_s.except))) begin
                exp.pc        = in_s.pc;
                exp.pc_target = in_s.pc_target;
            end
            if (prev_ctrl.flush)
                exp.except_code = 15'd0;
            else if (!prev_ctrl.hold && sys_or_brk(in_s))
                exp.except_code = in_s.except_code;   // even when paused or killed
            if (advance)
                exp.uop = in_s.uop;
            compare_field("vld", i, stage_group[i].vld, exp.vld);
            compare_field("except", i, stage_group[i].except, exp.except);
            compare_field("pc", i, stage_group[i].pc, exp.pc);
            compare_field("pc_target", i, stage_group[i].pc_target, exp.pc_target);
            compare_field("except_code", i, stage_group[i].except_code, exp.except_code);
            compare_field("uop", i, stage_group[i].uop, exp.uop);
            k = k || slot_traps(in_s);                  // squashes every younger slot
        end
    endtask

    always @(posedge clk) begin
        edge_rst <= rst_n;
    end

    // outputs settled and inputs not yet sampled by the next edge
    always @(negedge clk) begin
        if (!rst_n || !edge_rst)
            check_reset_state();
        else
            check_slots();
        prev_ctrl = ctrl;
        prev_in   = dec_group;
        prev_out  = stage_group;
    end

endmodule

/* bench/tb_rename_stage4.sv */
module tb_rename_stage4
    import rename_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_slots     = 4;
    localparam int reset_cycles  = 16;
    localparam int idle_cycles   = 4;
    localparam int pass_cycles   = 40;
    localparam int squash_cycles = 60;
    localparam int flush_cycles  = 30;
    localparam int hold_cycles   = 36;
    localparam int pause_cycles  = 40;
    localparam int mix_cycles    = 120;
    localparam int total_cycles  = reset_cycles + idle_cycles + pass_cycles + squash_cycles +
                                   flush_cycles + hold_cycles + pause_cycles + mix_cycles +
                                   7 * 2 + 4;     // drain cycles after each test

    logic                         clk = 1'b0;
    logic                         rst_n;
    stage_ctrl_t                  ctrl;
    decode_slot_t [num_slots-1:0] dec_group;
    decode_slot_t [num_slots-1:0] stage_group;
    int                           checks;
    int                           errors;

    logic [31:0] lcg_state = 32'hfac6_0c05;

    rename_stage4 #(
        .num_slots (num_slots)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .dec_group   (dec_group),
        .stage_group (stage_group)
    );

    rename_checks #(
        .num_slots (num_slots)
    ) chk (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .dec_group   (dec_group),
        .stage_group (stage_group),
        .checks      (checks),
        .errors      (errors)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic chance(input int pct);
        return ((lcg_next() >> 8) % 100) < pct;
    endfunction

    function automatic stage_ctrl_t random_ctrl(input int flush_pct, input int hold_pct,
                                                input int pause_pct);
        stage_ctrl_t c;
        c.flush = chance(flush_pct);
        c.hold  = chance(hold_pct);
        c.pause = chance(pause_pct);
        return c;
    endfunction

    function automatic decode_slot_t random_slot(input int exc_pct, input int sys_pct);
        decode_slot_t s;
        logic [31:0]  r;
        s.vld       = chance(80);
        s.pc        = lcg_next();
        s.pc_target = lcg_next();
        r = lcg_next();
        s.except      = 3'd0;
        if (chance(exc_pct))
            s.except = (r[10:8] == 3'd0) ? 3'b100 : r[10:8];
        s.except_code = r[30:16];
        r = lcg_next();
        s.uop.iq_choose = r[3:0];
        s.uop.alu0_op   = r[8:4];
        s.uop.alu1_op   = r[11:9];
        s.uop.agu_op    = r[15:12];
        s.uop.bru_op    = r[19:16];
        s.uop.rob_op    = r[23:20];
        if (chance(sys_pct))
            s.uop.rob_op = r[24] ? rob_op_break : rob_op_syscall;
        else if (s.uop.rob_op == rob_op_syscall || s.uop.rob_op == rob_op_break)
            s.uop.rob_op = s.uop.rob_op + 4'd4;       // plain op that does not trap
        r = lcg_next();
        s.uop.alu0_imm = r[19:0];
        r = lcg_next();
        s.uop.agu_imm = r[16:0];
        r = lcg_next();
        s.uop.bru_imm = r[25:0];
        return s;
    endfunction

    // youngest slot gets its own syscall bias since its trap kills nothing
    task automatic drive_group(input stage_ctrl_t c, input int exc_pct, input int sys_pct,
                               input int last_sys_pct);
        @(posedge clk);
        #1;
        ctrl = c;
        for (int i = 0; i < num_slots; i++)
            dec_group[i] = random_slot(exc_pct, (i == num_slots - 1) ? last_sys_pct : sys_pct);
    endtask

    task automatic report_test(input string name, input int chk0, input int err0);
        repeat (2) @(negedge clk);
        #1;
        $display("test %-8s %6d checks %4d errors", name, checks - chk0, errors - err0);
    endtask

    task automatic run_tests();
        stage_ctrl_t c;
        int          chk0;
        int          err0;

        chk0 = checks;
        err0 = errors;
        repeat (idle_cycles) begin
            @(posedge clk);
            #1;
            ctrl      = '0;
            dec_group = '0;
        end
        report_test("idle", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (pass_cycles) drive_group('0, 0, 0, 40);
        report_test("pass", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (squash_cycles) drive_group('0, 25, 25, 25);
        report_test("squash", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (flush_cycles) drive_group(random_ctrl(70, 50, 30), 20, 20, 20);
        report_test("flush", chk0, err0);

        chk0 = checks;
        err0 = errors;
        for (int n = 0; n < hold_cycles; n++) begin
            c       = random_ctrl(0, 0, 20);
            c.hold  = (n % 6) != 5;                    // runs of five held cycles
            drive_group(c, 20, 20, 20);
        end
        report_test("hold", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (pause_cycles) drive_group(random_ctrl(0, 0, 80), 20, 30, 30);
        report_test("pause", chk0, err0);

        chk0 = checks;
        err0 = errors;
        repeat (mix_cycles) drive_group(random_ctrl(10, 20, 20), 15, 15, 15);
        report_test("mix", chk0, err0);
    endtask

    initial begin
        rst_n     = 1'b0;
        ctrl      = '0;
        dec_group = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_tests();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(2 * total_cycles * 10);
        $display("run timed out after %0d ns before the tests finished", 2 * total_cycles * 10);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
rtl/rename_pkg.sv
rtl/trap_scan.sv
rtl/group_stage_reg.sv
rtl/rename_stage4.sv
bench/rename_checks.sv
bench/tb_rename_stage4.sv

/* Bender.yml */
package:
  name: rename_stage4

# RTL first, package ahead of its users
sources:
  - rtl/rename_pkg.sv
  - rtl/trap_scan.sv
  - rtl/group_stage_reg.sv
  - rtl/rename_stage4.sv

  # testbench, top module tb_rename_stage4
  - target: test
    files:
      - bench/rename_checks.sv
      - bench/tb_rename_stage4.sv
